//--- Makefile
SRCS := $(wildcard design/*.sv) $(wildcard verif/*.sv)

.PHONY: all run clean

all: run

obj_dir/Vdkong_tb: project.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module dkong_tb -f project.f -o Vdkong_tb

run: obj_dir/Vdkong_tb
	./obj_dir/Vdkong_tb | tee sim.log
	grep -q "TESTBENCH PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

//--- design/dkong_adec.sv
// Address decoder, Junior ROM remap, 5H control latch, vblank NMI, CPU clock enable
`default_nettype none

module dkong_adec import dkong_pkg::*; (
	input  wire logic        clk_24576m,
	input  wire logic        rst_n,
	input  wire cpu_bus_t    cpu,
	input  wire logic        game_dkjr,
	input  wire logic        vblank_n,
	output mem_sel_t         sel,
	output rom_addr_t        rom_addr,
	output ctrl_latch_t      latch,
	output logic             nmi_n,
	output logic             cpu_ce
);

	addr_t      rom_top;
	logic       latch_wr;
	logic       vblank_q;
	logic [2:0] phase;

	// ==================================================
	// Address decode
	// ==================================================
	// Junior program space runs up to 5FFF
	assign rom_top = game_dkjr ? ROM_TOP_DKJR : ROM_TOP_DK;

	always_comb begin
		sel = '0;
		if (!cpu.mreq_n) begin
			sel.rom  = (cpu.addr <= rom_top);
			// 1 KB RAM blocks
			sel.ram1 = (cpu.addr[15:10] == RAM1_BASE[15:10]);
			sel.ram2 = (cpu.addr[15:10] == RAM2_BASE[15:10]);
			sel.ram3 = (cpu.addr[15:10] == SPR_BASE[15:10]);
			// Input ports, 128 byte windows
			sel.in0  = (cpu.addr[15:7] == IN0_ADDR[15:7]);
			sel.in1  = (cpu.addr[15:7] == IN1_ADDR[15:7]);
			sel.in2  = (cpu.addr[15:7] == IN2_ADDR[15:7]);
			sel.dip  = (cpu.addr[15:7] == DIP_ADDR[15:7]);
		end
	end

	// Junior swaps 2 KB banks around in the ROM file
	always_comb begin
		rom_addr = cpu.addr;
		if (game_dkjr) begin
			case (cpu.addr[15:11])
				5'h02:   rom_addr = {5'h06, cpu.addr[10:0]};
				5'h03:   rom_addr = {5'h0B, cpu.addr[10:0]};
				5'h05:   rom_addr = {5'h09, cpu.addr[10:0]};
				5'h06:   rom_addr = {5'h02, cpu.addr[10:0]};
				5'h07:   rom_addr = {5'h03, cpu.addr[10:0]};
				5'h09:   rom_addr = {5'h05, cpu.addr[10:0]};
				5'h0B:   rom_addr = {5'h07, cpu.addr[10:0]};
				default: rom_addr = cpu.addr;
			endcase
		end
	end

	// ==================================================
	// 5H control latch
	// ==================================================
	// Addressable latch, one bit per address, data from D0
	assign latch_wr = !cpu.mreq_n && !cpu.wr_n && (cpu.addr[15:3] == LATCH_BASE[15:3]);

	always_ff @(posedge clk_24576m) begin
		if (!rst_n) begin
			latch <= '0;
		end else if (latch_wr) begin
			latch[cpu.addr[2:0]] <= cpu.dout[0];
		end
	end

	// ==================================================
	// NMI on falling vblank
	// ==================================================
	always_ff @(posedge clk_24576m) begin
		if (!rst_n) begin
			vblank_q <= 1'b1;
			nmi_n    <= 1'b1;
		end else begin
			vblank_q <= vblank_n;
			// Enable bit low holds NMI released
			if (!latch[4]) begin
				nmi_n <= 1'b1;
			end else if (vblank_q && !vblank_n) begin
				nmi_n <= 1'b0;
			end
		end
	end

	// CPU clock enable, one pulse per CE_DIV clocks
	always_ff @(posedge clk_24576m) begin
		if (!rst_n) begin
			phase <= '0;
		end else if (phase == 3'(CE_DIV - 1)) begin
			phase <= '0;
		end else begin
			phase <= phase + 3'd1;
		end
	end

	assign cpu_ce = (phase == 3'(CE_DIV - 1));

endmodule

`default_nettype wire

//--- design/dkong_cpu_rdbus.sv
// Input port formatting and registered OR merge of the CPU read sources
`default_nettype none

module dkong_cpu_rdbus import dkong_pkg::*; (
	input  wire logic       clk_24576m,
	input  wire logic       rst_n,
	input  wire mem_sel_t   sel,
	input  wire player_sw_t p1,
	input  wire player_sw_t p2,
	input  wire sys_sw_t    sys,
	input  wire data_t      dip,
	input  wire data_t      rom_data,
	input  wire data_t      ram1_data,
	input  wire data_t      ram2_data,
	input  wire data_t      spr_data,
	output data_t           cpu_din
);

	mem_sel_t sel_q;
	data_t    rom_q;
	data_t    in0_byte;
	data_t    in1_byte;
	data_t    in2_byte;
	data_t    rd_mux;

	// Player byte: jump, down, up, left, right in bits 4..0
	assign in0_byte = {3'b000, p1.jump, p1.down, p1.up, p1.left, p1.right};
	assign in1_byte = {3'b000, p2.jump, p2.down, p2.up, p2.left, p2.right};
	// Coin on top, starts in bits 3 and 2
	assign in2_byte = {sys.coin, 3'b000, sys.start2, sys.start1, 2'b00};

	// ROM data registered to line up with the RAM outputs
	always_ff @(posedge clk_24576m) begin
		rom_q <= rom_data;
	end

	// Gated OR of every source, zero when nothing selected
	always_comb begin
		rd_mux = ({8{sel_q.rom}}  & rom_q)
		       | ({8{sel_q.ram1}} & ram1_data)
		       | ({8{sel_q.ram2}} & ram2_data)
		       | ({8{sel_q.ram3}} & spr_data)
		       | ({8{sel_q.in0}}  & in0_byte)
		       | ({8{sel_q.in1}}  & in1_byte)
		       | ({8{sel_q.in2}}  & in2_byte)
		       | ({8{sel_q.dip}}  & dip);
	end

	always_ff @(posedge clk_24576m) begin
		if (!rst_n) begin
			sel_q   <= '0;
			cpu_din <= '0;
		end else begin
			sel_q   <= sel;
			cpu_din <= rd_mux;
		end
	end

endmodule

`default_nettype wire

//--- design/dkong_dma.sv
// Sprite DMA controller, bus request and sprite RAM to object RAM copy
`default_nettype none

module dkong_dma import dkong_pkg::*; (
	input  wire logic  clk_24576m,
	input  wire logic  rst_n,
	input  wire logic  cpu_ce,
	input  wire logic  trig,
	input  wire logic  busak,
	input  wire data_t src_data,
	output logic       busrq,
	output ram_addr_t  src_addr,
	output ram_addr_t  dst_addr,
	output data_t      dst_data,
	output logic       dst_we
);

	dma_state_t state;
	logic       trig_q;
	logic [8:0] count;
	logic [8:0] wr_addr;
	// Read issued, write still owed
	logic       pend;
	logic       issue;

	// ==================================================
	// Copy control
	// ==================================================
	// One read per CPU enable, never two writes owed
	assign issue = (state == DMA_COPY) && busak && cpu_ce && !pend;

	always_ff @(posedge clk_24576m) begin
		if (!rst_n) begin
			state  <= DMA_IDLE;
			trig_q <= 1'b0;
			pend   <= 1'b0;
			count  <= '0;
		end else begin
			trig_q <= trig;

			if (issue) begin
				pend <= 1'b1;
			end else if (pend && busak) begin
				pend <= 1'b0;
			end

			if (issue) begin
				count <= count + 9'd1;
			end

			case (state)
				DMA_IDLE: begin
					// Only a fresh 0 to 1 on the trigger bit
					if (trig && !trig_q) begin
						state <= DMA_REQ;
					end
				end
				DMA_REQ: begin
					if (busak) begin
						state <= DMA_COPY;
						count <= '0;
					end
				end
				DMA_COPY: begin
					if (issue && count == 9'(DMA_LEN - 1)) begin
						state <= DMA_DONE;
					end
				end
				DMA_DONE: begin
					// Hold the bus until the last byte lands
					if (!pend) begin
						state <= DMA_IDLE;
					end
				end
				default: state <= DMA_IDLE;
			endcase
		end
	end

	// Destination follows the read by one clock
	always_ff @(posedge clk_24576m) begin
		if (issue) begin
			wr_addr <= count;
		end
	end

	// ==================================================
	// Outputs
	// ==================================================
	// Keep the source address parked while a write waits, so the RAM output holds
	assign src_addr = {1'b0, (pend ? wr_addr : count)};
	assign dst_addr = {1'b0, wr_addr};
	assign dst_data = src_data;
	// Paused copy waits for the bus again
	assign dst_we   = pend && busak;
	assign busrq    = (state != DMA_IDLE);

endmodule

`default_nettype wire

//--- design/dkong_dpram.sv
// True dual-port 1024x8 RAM with synchronous read on both ports
`default_nettype none

module dkong_dpram import dkong_pkg::*; (
	input  wire logic      clk_24576m,
	// Port A
	input  wire ram_addr_t addr_a,
	input  wire data_t     din_a,
	input  wire logic      we_a,
	output data_t          dout_a,
	// Port B
	input  wire ram_addr_t addr_b,
	input  wire data_t     din_b,
	input  wire logic      we_b,
	output data_t          dout_b
);

	// 1024 bytes, sized from the address type
	data_t mem [2**$bits(ram_addr_t)];

	// Both ports read old data on a same-address write
	always_ff @(posedge clk_24576m) begin
		if (we_a) begin
			mem[addr_a] <= din_a;
		end
		if (we_b) begin
			mem[addr_b] <= din_b;
		end
		dout_a <= mem[addr_a];
		dout_b <= mem[addr_b];
	end

endmodule

`default_nettype wire

//--- design/dkong_main_top.sv
// CPU board top: decoder, work and sprite RAMs, object RAM, sprite DMA, read bus
`default_nettype none

module dkong_main_top import dkong_pkg::*; (
	input  wire logic       clk_24576m,
	input  wire logic       rst_n,
	// CPU side
	input  wire cpu_bus_t   cpu,
	input  wire logic       busak,
	output data_t           cpu_din,
	output logic            busrq,
	output logic            nmi_n,
	// Board config and video
	input  wire logic       game_dkjr,
	input  wire logic       vblank_n,
	output logic            flip,
	output logic            two_psl,
	// Switches
	input  wire player_sw_t p1,
	input  wire player_sw_t p2,
	input  wire sys_sw_t    sys,
	input  wire data_t      dip,
	// External program ROM
	output rom_addr_t       rom_addr,
	input  wire data_t      rom_data,
	// Object RAM video port
	input  wire ram_addr_t  obj_addr,
	output data_t           obj_data
);

	mem_sel_t    sel;
	ctrl_latch_t latch;
	logic        cpu_ce;
	ram_addr_t   cpu_ram_addr;
	data_t       ram1_q;
	data_t       ram2_q;
	data_t       spr_q;
	data_t       spr_dma_q;
	ram_addr_t   dma_src_addr;
	ram_addr_t   dma_dst_addr;
	data_t       dma_dst_data;
	logic        dma_dst_we;

	assign cpu_ram_addr = cpu.addr[9:0];
	assign flip         = latch[2];
	assign two_psl      = latch[3];

	// ==================================================
	// Decoder and latch
	// ==================================================
	dkong_adec adec_inst (
		.clk_24576m (clk_24576m),
		.rst_n      (rst_n),
		.cpu        (cpu),
		.game_dkjr  (game_dkjr),
		.vblank_n   (vblank_n),
		.sel        (sel),
		.rom_addr   (rom_addr),
		.latch      (latch),
		.nmi_n      (nmi_n),
		.cpu_ce     (cpu_ce)
	);

	// ==================================================
	// RAMs
	// ==================================================
	// Work RAM 6000, CPU on port A only
	dkong_dpram ram1_inst (
		.clk_24576m (clk_24576m),
		.addr_a     (cpu_ram_addr),
		.din_a      (cpu.dout),
		.we_a       (sel.ram1 && !cpu.wr_n),
		.dout_a     (ram1_q),
		.addr_b     ('0),
		.din_b      ('0),
		.we_b       (1'b0),
		.dout_b     ()
	);

	// Work RAM 6400
	dkong_dpram ram2_inst (
		.clk_24576m (clk_24576m),
		.addr_a     (cpu_ram_addr),
		.din_a      (cpu.dout),
		.we_a       (sel.ram2 && !cpu.wr_n),
		.dout_a     (ram2_q),
		.addr_b     ('0),
		.din_b      ('0),
		.we_b       (1'b0),
		.dout_b     ()
	);

	// Sprite RAM 7000, CPU on A, DMA reads on B
	dkong_dpram spr_ram_inst (
		.clk_24576m (clk_24576m),
		.addr_a     (cpu_ram_addr),
		.din_a      (cpu.dout),
		.we_a       (sel.ram3 && !cpu.wr_n),
		.dout_a     (spr_q),
		.addr_b     (dma_src_addr),
		.din_b      ('0),
		.we_b       (1'b0),
		.dout_b     (spr_dma_q)
	);

	// Object RAM, DMA writes on A, video reads on B
	dkong_dpram obj_ram_inst (
		.clk_24576m (clk_24576m),
		.addr_a     (dma_dst_addr),
		.din_a      (dma_dst_data),
		.we_a       (dma_dst_we),
		.dout_a     (),
		.addr_b     (obj_addr),
		.din_b      ('0),
		.we_b       (1'b0),
		.dout_b     (obj_data)
	);

	// Sprite DMA, triggered by latch bit 5
	dkong_dma dma_inst (
		.clk_24576m (clk_24576m),
		.rst_n      (rst_n),
		.cpu_ce     (cpu_ce),
		.trig       (latch[5]),
		.busak      (busak),
		.src_data   (spr_dma_q),
		.busrq      (busrq),
		.src_addr   (dma_src_addr),
		.dst_addr   (dma_dst_addr),
		.dst_data   (dma_dst_data),
		.dst_we     (dma_dst_we)
	);

	// CPU read data merge
	dkong_cpu_rdbus rdbus_inst (
		.clk_24576m (clk_24576m),
		.rst_n      (rst_n),
		.sel        (sel),
		.p1         (p1),
		.p2         (p2),
		.sys        (sys),
		.dip        (dip),
		.rom_data   (rom_data),
		.ram1_data  (ram1_q),
		.ram2_data  (ram2_q),
		.spr_data   (spr_q),
		.cpu_din    (cpu_din)
	);

endmodule

`default_nettype wire

//--- design/dkong_pkg.sv
// Bus and switch structs, latch type, DMA state enum, memory map constants
`default_nettype none

package dkong_pkg;

	// ==================================================
	// Basic widths
	// ==================================================
	typedef logic [15:0] addr_t;
	typedef logic [7:0]  data_t;
	typedef logic [9:0]  ram_addr_t;
	typedef logic [15:0] rom_addr_t;

	// 5H latch image
	// Bit 1 display, 2 flip, 3 2PSL, 4 NMI enable, 5 DMA trigger
	typedef logic [7:0] ctrl_latch_t;

	// Everything the CPU drives onto the board
	typedef struct packed {
		addr_t addr;
		data_t dout;
		logic  rd_n;
		logic  wr_n;
		logic  mreq_n;
	} cpu_bus_t;

	// Switches, active high
	typedef struct packed {
		logic up;
		logic down;
		logic left;
		logic right;
		logic jump;
	} player_sw_t;

	typedef struct packed {
		logic start1;
		logic start2;
		logic coin;
	} sys_sw_t;

	// Decoded selects, active high, only while MREQ is low
	typedef struct packed {
		logic rom;
		logic ram1;
		logic ram2;
		logic ram3;
		logic in0;
		logic in1;
		logic in2;
		logic dip;
	} mem_sel_t;

	typedef enum logic [1:0] {
		DMA_IDLE,
		DMA_REQ,
		DMA_COPY,
		DMA_DONE
	} dma_state_t;

	// ==================================================
	// Memory map
	// ==================================================
	localparam addr_t RAM1_BASE    = 16'h6000;
	localparam addr_t RAM2_BASE    = 16'h6400;
	localparam addr_t SPR_BASE     = 16'h7000;
	localparam addr_t IN0_ADDR     = 16'h7C00;
	localparam addr_t IN1_ADDR     = 16'h7C80;
	localparam addr_t IN2_ADDR     = 16'h7D00;
	localparam addr_t DIP_ADDR     = 16'h7D80;
	localparam addr_t LATCH_BASE   = 16'h7D80;
	localparam addr_t ROM_TOP_DK   = 16'h3FFF;
	localparam addr_t ROM_TOP_DKJR = 16'h5FFF;

	// Sprite copy length in bytes
	localparam int unsigned DMA_LEN = 384;
	// Clocks per CPU clock enable
	localparam int unsigned CE_DIV = 8;

endpackage

`default_nettype wire

//--- project.f
design/dkong_pkg.sv
design/dkong_adec.sv
design/dkong_dpram.sv
design/dkong_dma.sv
design/dkong_cpu_rdbus.sv
design/dkong_main_top.sv
verif/dkong_props.sv
verif/dkong_tb.sv

//--- verif/dkong_props.sv
// Bound properties on the sprite DMA handshake and the chip selects
`default_nettype none

module dkong_props import dkong_pkg::*; (
	input wire logic      clk_24576m,
	input wire logic      rst_n,
	input wire logic      busrq,
	input wire logic      busak,
	input wire logic      dst_we,
	input wire ram_addr_t dst_addr,
	input wire mem_sel_t  sel
);

	timeunit 1ns;
	timeprecision 1ps;

	int unsigned prop_errs = 0;

	// Bus released two clocks after the last object RAM write
	busrq_hold: assert property (@(posedge clk_24576m) disable iff (!rst_n)
		$fell(busrq) |-> $past(dst_we && dst_addr == ram_addr_t'(DMA_LEN - 1), 2))
	else begin
		prop_errs++;
		$error("busrq fell before the last object RAM write");
	end

	// Writes only inside a request that the CPU has granted
	we_needs_busak: assert property (@(posedge clk_24576m) disable iff (!rst_n)
		dst_we |-> busak && busrq)
	else begin
		prop_errs++;
		$error("object RAM write outside a granted bus request");
	end

	sel_onehot: assert property (@(posedge clk_24576m) disable iff (!rst_n)
		$onehot0(sel))
	else begin
		prop_errs++;
		$error("more than one chip select active");
	end

endmodule

bind dkong_main_top dkong_props props_inst (
	.clk_24576m (clk_24576m),
	.rst_n      (rst_n),
	.busrq      (busrq),
	.busak      (busak),
	.dst_we     (dma_dst_we),
	.dst_addr   (dma_dst_addr),
	.sel        (sel)
);

`default_nettype wire

//--- verif/dkong_tb.sv
// Testbench top: clock, reset, CPU bus tasks, directed tests, watchdog and summary
`default_nettype none

module dkong_tb import dkong_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	logic       clk_24576m;
	logic       rst_n;
	cpu_bus_t   cpu;
	logic       busak;
	logic       game_dkjr;
	logic       vblank_n;
	player_sw_t p1;
	player_sw_t p2;
	sys_sw_t    sys;
	data_t      dip;
	data_t      rom_data;
	ram_addr_t  obj_addr;
	data_t      cpu_din;
	logic       busrq;
	logic       nmi_n;
	rom_addr_t  rom_addr;
	data_t      obj_data;
	logic       flip;
	logic       two_psl;

	integer seed;
	int     errors;
	int     tests;

	dkong_main_top dkong_main_top_inst (
		.clk_24576m (clk_24576m),
		.rst_n      (rst_n),
		.cpu        (cpu),
		.busak      (busak),
		.cpu_din    (cpu_din),
		.busrq      (busrq),
		.nmi_n      (nmi_n),
		.game_dkjr  (game_dkjr),
		.vblank_n   (vblank_n),
		.flip       (flip),
		.two_psl    (two_psl),
		.p1         (p1),
		.p2         (p2),
		.sys        (sys),
		.dip        (dip),
		.rom_addr   (rom_addr),
		.rom_data   (rom_data),
		.obj_addr   (obj_addr),
		.obj_data   (obj_data)
	);

	// Behavioral program ROM, every address bit feeds the byte
	function automatic data_t rom_model(input rom_addr_t a);
		return a[7:0] ^ a[15:8] ^ 8'hA5;
	endfunction

	assign rom_data = rom_model(rom_addr);

	// Player port bit positions
	function automatic data_t player_port_byte(input player_sw_t p);
		data_t b;
		b    = 8'h00;
		b[4] = p.jump;
		b[3] = p.down;
		b[2] = p.up;
		b[1] = p.left;
		b[0] = p.right;
		return b;
	endfunction

	// IN2 bit positions
	function automatic data_t coin_start_byte(input sys_sw_t s);
		data_t b;
		b    = 8'h00;
		b[7] = s.coin;
		b[3] = s.start2;
		b[2] = s.start1;
		return b;
	endfunction

	initial begin
		clk_24576m = 1'b0;
		forever #5 clk_24576m = ~clk_24576m;
	end

	// ==================================================
	// Bus helpers
	// ==================================================
	task automatic bus_idle();
		cpu = '{addr: '0, dout: '0, rd_n: 1'b1, wr_n: 1'b1, mreq_n: 1'b1};
	endtask

	// Entered and left 1 ns after a rising edge
	task automatic cpu_write(input addr_t a, input data_t d);
		cpu.addr   = a;
		cpu.dout   = d;
		cpu.mreq_n = 1'b0;
		cpu.wr_n   = 1'b0;
		@(posedge clk_24576m);
		#1;
		bus_idle();
	endtask

	task automatic cpu_read(input addr_t a, output data_t d);
		cpu.addr   = a;
		cpu.mreq_n = 1'b0;
		cpu.rd_n   = 1'b0;
		// Data valid from the second edge
		repeat (2) @(posedge clk_24576m);
		#1;
		d = cpu_din;
		bus_idle();
	endtask

	task automatic check_byte(input string what, input data_t got, input data_t exp);
		assert (got == exp)
		else begin
			errors++;
			$display("FAIL %0d ns: %s read %02h, expected %02h", $time, what, got, exp);
		end
	endtask

	// Poll busrq for a level, give up after limit clocks
	task automatic wait_busrq(input logic level, input int limit, output logic ok);
		int n;
		n = 0;
		while (busrq !== level && n < limit) begin
			@(posedge clk_24576m);
			#1;
			n++;
		end
		ok = (busrq === level);
	endtask

	task automatic test_done(input string name, input int errs_at_start);
		tests++;
		if (errors == errs_at_start) begin
			$display("%s: ok", name);
		end else begin
			$display("%s: %0d errors", name, errors - errs_at_start);
		end
	endtask

	// ==================================================
	// Directed tests
	// ==================================================
	task automatic reset_test();
		int errs_at_start;
		errs_at_start = errors;
		check_byte("busrq", {7'b0, busrq}, 8'h00);
		check_byte("nmi_n", {7'b0, nmi_n}, 8'h01);
		check_byte("flip", {7'b0, flip}, 8'h00);
		check_byte("two_psl", {7'b0, two_psl}, 8'h00);
		check_byte("cpu_din", cpu_din, 8'h00);
		test_done("reset state", errs_at_start);
	endtask

	task automatic ram_test();
		int        errs_at_start;
		ram_addr_t off;
		data_t     d;
		data_t     got;
		errs_at_start = errors;
		for (int i = 0; i < 16; i++) begin
			off = 10'($random(seed));
			d   = 8'($random(seed));
			// Same offset in all three banks, distinct bytes
			cpu_write({RAM1_BASE[15:10], off}, d);
			cpu_write({RAM2_BASE[15:10], off}, d ^ 8'h55);
			cpu_write({SPR_BASE[15:10], off}, d ^ 8'hAA);
			cpu_read({RAM1_BASE[15:10], off}, got);
			check_byte("ram1", got, d);
			cpu_read({RAM2_BASE[15:10], off}, got);
			check_byte("ram2", got, d ^ 8'h55);
			cpu_read({SPR_BASE[15:10], off}, got);
			check_byte("sprite RAM", got, d ^ 8'hAA);
		end
		test_done("work and sprite RAM", errs_at_start);
	endtask

	task automatic input_test();
		int    errs_at_start;
		data_t got;
		errs_at_start = errors;
		for (int i = 0; i < 4; i++) begin
			p1  = 5'($random(seed));
			p2  = 5'($random(seed));
			sys = 3'($random(seed));
			dip = 8'($random(seed));
			cpu_read(IN0_ADDR, got);
			check_byte("IN0", got, player_port_byte(p1));
			cpu_read(IN1_ADDR, got);
			check_byte("IN1", got, player_port_byte(p2));
			cpu_read(IN2_ADDR, got);
			check_byte("IN2", got, coin_start_byte(sys));
			cpu_read(DIP_ADDR, got);
			check_byte("DIP", got, dip);
		end
		// Hole between sprite RAM and the ports
		cpu_read(16'h7800, got);
		check_byte("unmapped 7800", got, 8'h00);
		test_done("input ports", errs_at_start);
	endtask

	task automatic rom_check(input logic dkjr, input addr_t a, input addr_t file_addr);
		data_t got;
		game_dkjr = dkjr;
		cpu_read(a, got);
		check_byte($sformatf("ROM %04h", a), got, rom_model(file_addr));
	endtask

	task automatic rom_test();
		int    errs_at_start;
		addr_t off;
		data_t got;
		errs_at_start = errors;
		off = {5'b0, 11'($random(seed))};
		// Junior bank swaps
		rom_check(1'b1, 16'h1000 | off, 16'h3000 | off);
		rom_check(1'b1, 16'h1800 | off, 16'h5800 | off);
		rom_check(1'b1, 16'h2800 | off, 16'h4800 | off);
		rom_check(1'b1, 16'h3000 | off, 16'h1000 | off);
		rom_check(1'b1, 16'h3800 | off, 16'h1800 | off);
		rom_check(1'b1, 16'h4800 | off, 16'h2800 | off);
		rom_check(1'b1, 16'h5800 | off, 16'h3800 | off);
		rom_check(1'b1, 16'h2000 | off, 16'h2000 | off);
		// Plain Donkey Kong, no remap
		rom_check(1'b0, 16'h1000 | off, 16'h1000 | off);
		rom_check(1'b0, 16'h3800 | off, 16'h3800 | off);
		cpu_read(16'h4800 | off, got);
		check_byte("ROM above 3FFF", got, 8'h00);
		test_done("program ROM", errs_at_start);
	endtask

	task automatic latch_nmi_test();
		int errs_at_start;
		errs_at_start = errors;
		cpu_write(16'h7D82, 8'h01);
		check_byte("flip set", {7'b0, flip}, 8'h01);
		cpu_write(16'h7D83, 8'h01);
		check_byte("two_psl set", {7'b0, two_psl}, 8'h01);
		// Only D0 counts
		cpu_write(16'h7D82, 8'hFE);
		cpu_write(16'h7D83, 8'hFE);
		check_byte("flip clear", {7'b0, flip}, 8'h00);
		check_byte("two_psl clear", {7'b0, two_psl}, 8'h00);

		cpu_write(16'h7D84, 8'h01);
		vblank_n = 1'b0;
		@(posedge clk_24576m);
		#1;
		vblank_n = 1'b1;
		check_byte("nmi_n after vblank", {7'b0, nmi_n}, 8'h00);
		cpu_write(16'h7D84, 8'h00);
		@(posedge clk_24576m);
		#1;
		check_byte("nmi_n after disable", {7'b0, nmi_n}, 8'h01);

		// Disabled, vblank must not reach the CPU
		vblank_n = 1'b0;
		repeat (2) @(posedge clk_24576m);
		#1;
		vblank_n = 1'b1;
		check_byte("nmi_n while disabled", {7'b0, nmi_n}, 8'h01);
		test_done("latch and NMI", errs_at_start);
	endtask

	task automatic dma_test();
		int    errs_at_start;
		data_t d;
		data_t spr_exp [$];
		logic  ok;
		errs_at_start = errors;
		for (int i = 0; i < int'(DMA_LEN); i++) begin
			d = 8'($random(seed));
			spr_exp.push_back(d);
			cpu_write({SPR_BASE[15:10], 10'(i)}, d);
		end

		cpu_write(16'h7D85, 8'h01);
		wait_busrq(1'b1, 2, ok);
		assert (ok)
		else begin
			errors++;
			$display("busrq did not rise within 2 clocks of the DMA trigger");
		end
		busak = 1'b1;
		// One byte per CPU enable, plus slack
		wait_busrq(1'b0, int'(CE_DIV) * int'(DMA_LEN) + 64, ok);
		assert (ok)
		else begin
			errors++;
			$display("DMA copy never finished, busrq still high");
		end
		busak = 1'b0;

		for (int i = 0; i < int'(DMA_LEN); i++) begin
			obj_addr = 10'(i);
			@(posedge clk_24576m);
			#1;
			check_byte($sformatf("object RAM %0d", i), obj_data, spr_exp[i]);
		end

		// Bit 5 still set, so no fresh edge
		cpu_write(16'h7D85, 8'h01);
		wait_busrq(1'b1, 16, ok);
		assert (!ok)
		else begin
			errors++;
			$display("busrq rose again on a repeated trigger with no 0 write");
		end
		cpu_write(16'h7D85, 8'h00);
		test_done("sprite DMA", errs_at_start);
	endtask

	// ==================================================
	// Main sequence
	// ==================================================
	initial begin
		seed      = 50233;
		errors    = 0;
		tests     = 0;
		rst_n     = 1'b0;
		busak     = 1'b0;
		game_dkjr = 1'b0;
		vblank_n  = 1'b1;
		p1        = '0;
		p2        = '0;
		sys       = '0;
		dip       = '0;
		obj_addr  = '0;
		bus_idle();
		repeat (10) @(posedge clk_24576m);
		#1;
		rst_n = 1'b1;

		reset_test();
		ram_test();
		input_test();
		rom_test();
		latch_nmi_test();
		dma_test();

		assert (dkong_main_top_inst.props_inst.prop_errs == 0)
		else begin
			errors++;
			$display("bound DMA and select properties failed");
		end
		$display("%0d tests run, %0d errors", tests, errors);
		if (errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

	// Whole run is about 5000 clocks, DMA copy dominates
	initial begin
		repeat (20000) @(posedge clk_24576m);
		$display("watchdog expired after 20000 clocks, run did not finish");
		$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

`default_nettype wire
